//--- verilog/rrag_pkg.sv
package rrag_pkg;

    localparam int data_w = 32;
    localparam int gpr_aw = 3;
    localparam int seg_aw = 3;
    localparam int num_seg = 6;
    localparam int seg_w = 16;
    localparam int lim_w = 20;
    localparam int tag_w = 7;

    // Operand size codes, code 3 behaves as dword
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_word = 2'd1;
    localparam logic [1:0] size_dword = 2'd2;

    // Segment register numbering
    localparam int seg_es = 0;
    localparam int seg_cs = 1;
    localparam int seg_ss = 2;
    localparam int seg_ds = 3;
    localparam int seg_fs = 4;
    localparam int seg_gs = 5;

    // Linear contribution of a segment base is base << seg_shift
    localparam int seg_shift = 16;

    function automatic logic [num_seg-1:0][lim_w-1:0] init_limits();
        logic [num_seg-1:0][lim_w-1:0] t;
        t = '0;
        t[seg_es] = 20'h04fff;
        t[seg_cs] = 20'h0ffff;
        t[seg_ss] = 20'h1ffff;
        t[seg_ds] = 20'h00fff;
        t[seg_fs] = 20'hfffff;
        t[seg_gs] = 20'h03fff;
        return t;
    endfunction

    localparam logic [num_seg-1:0][lim_w-1:0] seg_limit_init = init_limits();

endpackage

//--- verilog/gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rrag_pkg::gpr_aw-1:0] rd_addr1,
    input  logic [rrag_pkg::gpr_aw-1:0] rd_addr2,
    input  logic [rrag_pkg::gpr_aw-1:0] rd_addr3,
    input  logic [rrag_pkg::gpr_aw-1:0] rd_addr4,
    input  logic [1:0]                  rd_size,
    output logic [rrag_pkg::data_w-1:0] rd_data1,
    output logic [rrag_pkg::data_w-1:0] rd_data2,
    output logic [rrag_pkg::data_w-1:0] rd_data3,
    output logic [rrag_pkg::data_w-1:0] rd_data4,
    output logic                        rd_pending1,
    output logic                        rd_pending2,
    output logic                        rd_pending3,
    output logic                        rd_pending4,
    input  logic                        wb_en,
    input  logic [rrag_pkg::gpr_aw-1:0] wb_addr,
    input  logic [rrag_pkg::data_w-1:0] wb_data,
    input  logic [1:0]                  wb_size,
    input  logic [rrag_pkg::tag_w-1:0]  wb_tag,
    input  logic                        reserve_en,
    input  logic [rrag_pkg::gpr_aw-1:0] reserve_addr,
    input  logic [rrag_pkg::tag_w-1:0]  reserve_tag
);
    import rrag_pkg::*;

    logic [data_w-1:0] regs [2**gpr_aw];
    logic [tag_w-1:0]  tags [2**gpr_aw];
    logic [2**gpr_aw-1:0] pending;
    logic [data_w-1:0] wb_mask;

    // Bits touched by an access of the given size
    function automatic logic [data_w-1:0] size_mask(input logic [1:0] size);
        logic [data_w-1:0] m;
        case (size)
            size_byte:  m = data_w'(8'hff);
            size_word:  m = data_w'(16'hffff);
            size_dword: m = '1;
            default:    m = '1;
        endcase
        return m;
    endfunction

    assign wb_mask = size_mask(wb_size);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < 2**gpr_aw; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (wb_en) begin
                regs[wb_addr] <= (regs[wb_addr] & ~wb_mask) | (wb_data & wb_mask);
                // Only the youngest writer releases the register
                if (wb_tag == tags[wb_addr]) begin
                    pending[wb_addr] <= 1'b0;
                end
            end
            // Placed last so a same-cycle reservation keeps the entry pending
            if (reserve_en) begin
                pending[reserve_addr] <= 1'b1;
                tags[reserve_addr] <= reserve_tag;
            end
        end
    end

    assign rd_data1 = regs[rd_addr1] & size_mask(rd_size);
    assign rd_data2 = regs[rd_addr2] & size_mask(rd_size);
    assign rd_data3 = regs[rd_addr3] & size_mask(rd_size);
    assign rd_data4 = regs[rd_addr4] & size_mask(rd_size);

    assign rd_pending1 = pending[rd_addr1];
    assign rd_pending2 = pending[rd_addr2];
    assign rd_pending3 = pending[rd_addr3];
    assign rd_pending4 = pending[rd_addr4];

endmodule

//--- verilog/seg_file.sv
`timescale 1ns/1ps

module seg_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rrag_pkg::seg_aw-1:0] rd_addr1,
    input  logic [rrag_pkg::seg_aw-1:0] rd_addr2,
    output logic [rrag_pkg::seg_w-1:0]  rd_base1,
    output logic [rrag_pkg::seg_w-1:0]  rd_base2,
    output logic [rrag_pkg::lim_w-1:0]  rd_limit1,
    output logic [rrag_pkg::lim_w-1:0]  rd_limit2,
    output logic                        rd_pending1,
    output logic                        rd_pending2,
    input  logic                        wb_en,
    input  logic [rrag_pkg::seg_aw-1:0] wb_addr,
    input  logic [rrag_pkg::seg_w-1:0]  wb_data,
    input  logic [rrag_pkg::tag_w-1:0]  wb_tag,
    input  logic                        reserve_en,
    input  logic [rrag_pkg::seg_aw-1:0] reserve_addr,
    input  logic [rrag_pkg::tag_w-1:0]  reserve_tag
);
    import rrag_pkg::*;

    logic [seg_w-1:0]   bases [num_seg];
    logic [tag_w-1:0]   tags [num_seg];
    logic [num_seg-1:0] pending;
    logic               rd_ok1;
    logic               rd_ok2;

    // Indices 6 and 7 name no segment
    assign rd_ok1 = rd_addr1 < seg_aw'(num_seg);
    assign rd_ok2 = rd_addr2 < seg_aw'(num_seg);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < num_seg; i++) begin
                bases[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (wb_en && wb_addr < seg_aw'(num_seg)) begin
                bases[wb_addr] <= wb_data;
                if (wb_tag == tags[wb_addr]) begin
                    pending[wb_addr] <= 1'b0;
                end
            end
            if (reserve_en && reserve_addr < seg_aw'(num_seg)) begin
                pending[reserve_addr] <= 1'b1;
                tags[reserve_addr] <= reserve_tag;
            end
        end
    end

    assign rd_base1 = rd_ok1 ? bases[rd_addr1] : '0;
    assign rd_base2 = rd_ok2 ? bases[rd_addr2] : '0;
    assign rd_limit1 = rd_ok1 ? seg_limit_init[rd_addr1] : '0;
    assign rd_limit2 = rd_ok2 ? seg_limit_init[rd_addr2] : '0;
    assign rd_pending1 = rd_ok1 && pending[rd_addr1];
    assign rd_pending2 = rd_ok2 && pending[rd_addr2];

endmodule

//--- verilog/addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
    input  logic [rrag_pkg::data_w-1:0] base_reg,
    input  logic [rrag_pkg::data_w-1:0] index_reg,
    input  logic [rrag_pkg::data_w-1:0] off2_reg,
    input  logic [rrag_pkg::seg_w-1:0]  seg_base1,
    input  logic [rrag_pkg::seg_w-1:0]  seg_base2,
    input  logic [rrag_pkg::lim_w-1:0]  seg_limit1,
    input  logic [rrag_pkg::lim_w-1:0]  seg_limit2,
    input  logic [rrag_pkg::data_w-1:0] disp,
    input  logic [1:0]                  ss,
    input  logic                        is_sib,
    input  logic [1:0]                  opsize,
    output logic [rrag_pkg::data_w-1:0] mem_addr1,
    output logic [rrag_pkg::data_w-1:0] mem_addr2,
    output logic [rrag_pkg::data_w-1:0] mem_addr1_end,
    output logic [rrag_pkg::data_w-1:0] mem_addr2_end,
    output logic                        seg_fault1,
    output logic                        seg_fault2
);
    import rrag_pkg::*;

    logic [data_w-1:0] scaled_index;
    logic [data_w-1:0] sib_sum;
    logic [data_w-1:0] offset1;
    logic [data_w-1:0] offset2;
    logic [data_w-1:0] len_m1;
    logic [data_w-1:0] end_off1;
    logic [data_w-1:0] end_off2;
    logic [data_w-1:0] seg_lin1;
    logic [data_w-1:0] seg_lin2;

    // Scale of 1, 2, 4 or 8
    assign scaled_index = index_reg << ss;
    assign sib_sum = base_reg + scaled_index;
    assign offset1 = (is_sib ? sib_sum : base_reg) + disp;
    assign offset2 = off2_reg;

    // Access length minus one
    always_comb begin
        case (opsize)
            size_byte: len_m1 = data_w'(0);
            size_word: len_m1 = data_w'(1);
            default:   len_m1 = data_w'(3);
        endcase
    end

    assign end_off1 = offset1 + len_m1;
    assign end_off2 = offset2 + len_m1;

    assign seg_lin1 = data_w'(seg_base1) << seg_shift;
    assign seg_lin2 = data_w'(seg_base2) << seg_shift;

    assign mem_addr1 = offset1 + seg_lin1;
    assign mem_addr2 = offset2 + seg_lin2;
    assign mem_addr1_end = end_off1 + seg_lin1;
    assign mem_addr2_end = end_off2 + seg_lin2;

    // Last byte beyond the limit, offsets wrap at 32 bits
    assign seg_fault1 = end_off1 > data_w'(seg_limit1);
    assign seg_fault2 = end_off2 > data_w'(seg_limit2);

endmodule

//--- verilog/rrag.sv
`timescale 1ns/1ps

module rrag (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        valid_in,
    input  logic [rrag_pkg::gpr_aw-1:0] reg_addr1,
    input  logic [rrag_pkg::gpr_aw-1:0] reg_addr2,
    input  logic [rrag_pkg::gpr_aw-1:0] reg_addr3,
    input  logic [rrag_pkg::gpr_aw-1:0] reg_addr4,
    input  logic [rrag_pkg::seg_aw-1:0] seg_addr1,
    input  logic [rrag_pkg::seg_aw-1:0] seg_addr2,
    input  logic [1:0]                  opsize_in,
    input  logic [rrag_pkg::data_w-1:0] disp,
    input  logic [1:0]                  ss,
    input  logic                        is_sib,
    input  logic                        dest_reg_en,
    input  logic [rrag_pkg::gpr_aw-1:0] dest_reg_addr,
    input  logic                        dest_seg_en,
    input  logic [rrag_pkg::seg_aw-1:0] dest_seg_addr,
    input  logic                        wb_reg_en,
    input  logic [rrag_pkg::gpr_aw-1:0] wb_addr,
    input  logic [rrag_pkg::data_w-1:0] wb_data,
    input  logic [1:0]                  wb_opsize,
    input  logic [rrag_pkg::tag_w-1:0]  wb_tag,
    input  logic                        wb_seg_en,
    input  logic [rrag_pkg::seg_aw-1:0] wb_seg_addr,
    input  logic [rrag_pkg::seg_w-1:0]  wb_seg_data,
    input  logic [rrag_pkg::tag_w-1:0]  wb_seg_tag,
    input  logic                        fwd_stall,
    output logic                        valid_out,
    output logic                        stall,
    output logic [rrag_pkg::tag_w-1:0]  inst_tag,
    output logic [rrag_pkg::data_w-1:0] reg1,
    output logic [rrag_pkg::data_w-1:0] reg2,
    output logic [rrag_pkg::data_w-1:0] reg3,
    output logic [rrag_pkg::data_w-1:0] reg4,
    output logic [rrag_pkg::seg_w-1:0]  seg1,
    output logic [rrag_pkg::seg_w-1:0]  seg2,
    output logic [rrag_pkg::data_w-1:0] mem_addr1,
    output logic [rrag_pkg::data_w-1:0] mem_addr2,
    output logic [rrag_pkg::data_w-1:0] mem_addr1_end,
    output logic [rrag_pkg::data_w-1:0] mem_addr2_end,
    output logic                        seg_fault1,
    output logic                        seg_fault2,
    output logic [1:0]                  opsize_out,
    output logic [rrag_pkg::gpr_aw-1:0] dest_reg_out,
    output logic [rrag_pkg::seg_aw-1:0] dest_seg_out
);
    import rrag_pkg::*;

    logic [tag_w-1:0]  tag_cnt;
    logic              accept;
    logic              src_pending;
    logic [data_w-1:0] rd_reg1;
    logic [data_w-1:0] rd_reg2;
    logic [data_w-1:0] rd_reg3;
    logic [data_w-1:0] rd_reg4;
    logic [3:0]        reg_pend;
    logic [seg_w-1:0]  rd_seg1;
    logic [seg_w-1:0]  rd_seg2;
    logic [lim_w-1:0]  rd_lim1;
    logic [lim_w-1:0]  rd_lim2;
    logic [1:0]        seg_pend;
    logic [data_w-1:0] ag_addr1;
    logic [data_w-1:0] ag_addr2;
    logic [data_w-1:0] ag_addr1_end;
    logic [data_w-1:0] ag_addr2_end;
    logic              ag_fault1;
    logic              ag_fault2;

    gpr_file gpr_i (
        .clk(clk), .reset(reset),
        .rd_addr1(reg_addr1), .rd_addr2(reg_addr2),
        .rd_addr3(reg_addr3), .rd_addr4(reg_addr4), .rd_size(opsize_in),
        .rd_data1(rd_reg1), .rd_data2(rd_reg2), .rd_data3(rd_reg3), .rd_data4(rd_reg4),
        .rd_pending1(reg_pend[0]), .rd_pending2(reg_pend[1]),
        .rd_pending3(reg_pend[2]), .rd_pending4(reg_pend[3]),
        .wb_en(wb_reg_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .wb_size(wb_opsize), .wb_tag(wb_tag),
        .reserve_en(accept && dest_reg_en), .reserve_addr(dest_reg_addr),
        .reserve_tag(tag_cnt)
    );

    seg_file seg_i (
        .clk(clk), .reset(reset),
        .rd_addr1(seg_addr1), .rd_addr2(seg_addr2),
        .rd_base1(rd_seg1), .rd_base2(rd_seg2), .rd_limit1(rd_lim1), .rd_limit2(rd_lim2),
        .rd_pending1(seg_pend[0]), .rd_pending2(seg_pend[1]),
        .wb_en(wb_seg_en), .wb_addr(wb_seg_addr), .wb_data(wb_seg_data), .wb_tag(wb_seg_tag),
        .reserve_en(accept && dest_seg_en), .reserve_addr(dest_seg_addr),
        .reserve_tag(tag_cnt)
    );

    addr_gen ag_i (
        .base_reg(rd_reg2), .index_reg(rd_reg3), .off2_reg(rd_reg4),
        .seg_base1(rd_seg1), .seg_base2(rd_seg2),
        .seg_limit1(rd_lim1), .seg_limit2(rd_lim2),
        .disp(disp), .ss(ss), .is_sib(is_sib), .opsize(opsize_in),
        .mem_addr1(ag_addr1), .mem_addr2(ag_addr2),
        .mem_addr1_end(ag_addr1_end), .mem_addr2_end(ag_addr2_end),
        .seg_fault1(ag_fault1), .seg_fault2(ag_fault2)
    );

    // Every source counts as used
    assign src_pending = (|reg_pend) || (|seg_pend);
    assign stall = (valid_in && src_pending) || fwd_stall;
    assign accept = valid_in && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_cnt <= '0;
            valid_out <= 1'b0;
        end else begin
            if (accept) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
            // A source stall leaves a bubble behind
            if (!fwd_stall) begin
                valid_out <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fwd_stall) begin
            inst_tag <= tag_cnt;
            reg1 <= rd_reg1;
            reg2 <= rd_reg2;
            reg3 <= rd_reg3;
            reg4 <= rd_reg4;
            seg1 <= rd_seg1;
            seg2 <= rd_seg2;
            mem_addr1 <= ag_addr1;
            mem_addr2 <= ag_addr2;
            mem_addr1_end <= ag_addr1_end;
            mem_addr2_end <= ag_addr2_end;
            seg_fault1 <= ag_fault1;
            seg_fault2 <= ag_fault2;
            opsize_out <= opsize_in;
            dest_reg_out <= dest_reg_addr;
            dest_seg_out <= dest_seg_addr;
        end
    end

endmodule

//--- sim/rrag_tests.svh
task automatic test_partial_writes();
    for (int i = 0; i < 8; i++) begin
        write_reg(3'(i), next_rand(), size_dword, 7'd0);
    end
    // Byte writes to even registers, word writes to odd ones
    for (int i = 0; i < 8; i++) begin
        write_reg(3'(i), next_rand(), (i % 2 == 0) ? size_byte : size_word, 7'd0);
    end
    for (int size = 0; size < 4; size++) begin
        for (int half = 0; half < 2; half++) begin
            load_inst(3'(4 * half), 3'(4 * half + 1), 3'(4 * half + 2), 3'(4 * half + 3),
                      3'(seg_cs), 3'(seg_ds), 2'(size), next_rand(), 2'd0, 1'b0);
            issue("size-aware read");
        end
    end
endtask

task automatic test_addr_gen();
    for (int s = 0; s < num_seg; s++) begin
        write_seg(3'(s), 16'(next_rand()), 7'd0);
    end
    for (int i = 0; i < 8; i++) begin
        write_reg(3'(i), next_rand(), size_dword, 7'd0);
    end
    for (int sib = 0; sib < 2; sib++) begin
        for (int sc = 0; sc < 4; sc++) begin
            for (int size = 0; size < 4; size++) begin
                load_random_inst();
                is_sib = 1'(sib);
                ss = 2'(sc);
                opsize_in = 2'(size);
                issue("address generation");
            end
        end
    end
endtask

task automatic test_limit_faults();
    logic [31:0] len;
    logic [31:0] lim;
    logic [31:0] off;
    write_reg(3'd0, 32'd0, size_dword, 7'd0);
    for (int s = 0; s < num_seg; s++) begin
        for (int size = 0; size < 3; size++) begin
            for (int k = 0; k < 3; k++) begin
                len = 32'd1 << size;
                lim = 32'(seg_limit_init[s]);
                // Last byte on the limit, first byte on the limit, first byte past it
                case (k)
                    0:       off = lim - len + 32'd1;
                    1:       off = lim;
                    default: off = lim + 32'd1;
                endcase
                write_reg(3'd4, off, size_dword, 7'd0);
                load_inst(3'd0, 3'd0, 3'd0, 3'd4, 3'(s), 3'(s), 2'(size), off, 2'd0, 1'b0);
                issue("limit fault");
                check_equal(32'(seg_fault1), 32'((k == 2) || (k == 1 && size > 0)),
                            "fault position against limit");
                // Only a dword read carries the whole offset into operand 2
                if (size == 2) begin
                    check_equal(32'(seg_fault2), 32'(k != 0),
                                "second fault position against limit");
                end
            end
        end
    end
endtask

task automatic test_scoreboard();
    logic [tag_w-1:0] a_tag;
    logic [31:0]      data;
    load_inst(3'd0, 3'd1, 3'd2, 3'd3, 3'(seg_ds), 3'(seg_ds), size_dword, 32'd0, 2'd0, 1'b0);
    dest_reg_en = 1'b1;
    dest_reg_addr = 3'd5;
    dest_seg_en = 1'b1;
    dest_seg_addr = 3'(seg_fs);
    issue("producer of r5 and fs");
    a_tag = inst_tag;
    // Reader of r5 held upstream while a stale writer returns
    load_inst(3'd0, 3'd1, 3'd5, 3'd3, 3'(seg_ds), 3'(seg_ds), size_dword, 32'd0, 2'd0, 1'b0);
    valid_in = 1'b1;
    data = next_rand();
    drive_reg_wb(3'd5, data, size_dword, a_tag ^ 7'd1);
    #2;
    check_equal(32'(stall), 32'(model_stall()), "stall on pending source");
    @(negedge clk);
    wb_reg_en = 1'b0;
    apply_reg_write(3'd5, data, size_dword, a_tag ^ 7'd1);
    #2;
    check_equal(32'(stall), 32'(model_stall()), "stall after wrong tag");
    @(negedge clk);
    check_equal(32'(valid_out), 32'd0, "bubble while stalled");
    check_equal(reg3, model_read(3'd5, size_dword), "data of wrong-tag writeback");
    data = next_rand();
    drive_reg_wb(3'd5, data, size_dword, a_tag);
    #2;
    check_equal(32'(stall), 32'd1, "release is not bypassed");
    @(negedge clk);
    wb_reg_en = 1'b0;
    apply_reg_write(3'd5, data, size_dword, a_tag);
    issue("released reader");
    // The segment side follows the same release rule
    load_inst(3'd0, 3'd1, 3'd2, 3'd3, 3'(seg_ds), 3'(seg_fs), size_dword, 32'd0, 2'd0, 1'b0);
    valid_in = 1'b1;
    write_seg(3'(seg_fs), 16'(next_rand()), a_tag ^ 7'd1);
    #2;
    check_equal(32'(stall), 32'(model_stall()), "stall on pending segment");
    @(negedge clk);
    write_seg(3'(seg_fs), 16'(next_rand()), a_tag);
    issue("released segment reader");
endtask

task automatic test_tags_backpressure();
    logic [tag_w-1:0] prev_tag;
    logic [tag_w-1:0] next_tag;
    prev_tag = '0;
    for (int n = 0; n < 4; n++) begin
        load_random_inst();
        issue("consecutive instruction");
        next_tag = prev_tag + 7'd1;
        if (n > 0) begin
            check_equal(32'(inst_tag), 32'(next_tag), "tag increment");
        end
        prev_tag = exp_tag;
    end
    // Next instruction waits upstream while the output stage is held
    load_random_inst();
    valid_in = 1'b1;
    fwd_stall = 1'b1;
    repeat (3) begin
        #2;
        check_equal(32'(stall), 32'(model_stall()), "stall under fwd_stall");
        @(negedge clk);
        check_outputs("held under fwd_stall");
    end
    fwd_stall = 1'b0;
    issue("after fwd_stall");
    next_tag = prev_tag + 7'd1;
    check_equal(32'(inst_tag), 32'(next_tag), "tag after hold");
endtask

//--- sim/rrag_tb.sv
`timescale 1ns/1ps

module rrag_tb;
    import rrag_pkg::*;

    localparam int clk_period = 20;
    localparam int num_tests = 5;
    localparam int cycles_per_test = 400;
    localparam int timeout_ns = 2 * (16 + num_tests * cycles_per_test) * clk_period;

    logic              clk = 1'b0;
    logic              reset;
    logic              valid_in;
    logic [gpr_aw-1:0] reg_addr1;
    logic [gpr_aw-1:0] reg_addr2;
    logic [gpr_aw-1:0] reg_addr3;
    logic [gpr_aw-1:0] reg_addr4;
    logic [seg_aw-1:0] seg_addr1;
    logic [seg_aw-1:0] seg_addr2;
    logic [1:0]        opsize_in;
    logic [data_w-1:0] disp;
    logic [1:0]        ss;
    logic              is_sib;
    logic              dest_reg_en;
    logic [gpr_aw-1:0] dest_reg_addr;
    logic              dest_seg_en;
    logic [seg_aw-1:0] dest_seg_addr;
    logic              wb_reg_en;
    logic [gpr_aw-1:0] wb_addr;
    logic [data_w-1:0] wb_data;
    logic [1:0]        wb_opsize;
    logic [tag_w-1:0]  wb_tag;
    logic              wb_seg_en;
    logic [seg_aw-1:0] wb_seg_addr;
    logic [seg_w-1:0]  wb_seg_data;
    logic [tag_w-1:0]  wb_seg_tag;
    logic              fwd_stall;
    logic              valid_out;
    logic              stall;
    logic [tag_w-1:0]  inst_tag;
    logic [data_w-1:0] reg1;
    logic [data_w-1:0] reg2;
    logic [data_w-1:0] reg3;
    logic [data_w-1:0] reg4;
    logic [seg_w-1:0]  seg1;
    logic [seg_w-1:0]  seg2;
    logic [data_w-1:0] mem_addr1;
    logic [data_w-1:0] mem_addr2;
    logic [data_w-1:0] mem_addr1_end;
    logic [data_w-1:0] mem_addr2_end;
    logic              seg_fault1;
    logic              seg_fault2;
    logic [1:0]        opsize_out;
    logic [gpr_aw-1:0] dest_reg_out;
    logic [seg_aw-1:0] dest_seg_out;

    // Shadow state, segment entries 6 and 7 are never written
    logic [data_w-1:0] model_regs [8];
    logic [tag_w-1:0]  model_tag_reg [8];
    logic [7:0]        model_pend_reg;
    logic [seg_w-1:0]  model_seg [8];
    logic [tag_w-1:0]  model_tag_seg [8];
    logic [7:0]        model_pend_seg;
    logic [tag_w-1:0]  model_tag;
    logic [31:0]       rng_state = 32'd95572;

    // Expected outputs of the last accepted instruction
    logic [data_w-1:0] exp_reg1;
    logic [data_w-1:0] exp_reg2;
    logic [data_w-1:0] exp_reg3;
    logic [data_w-1:0] exp_reg4;
    logic [seg_w-1:0]  exp_seg1;
    logic [seg_w-1:0]  exp_seg2;
    logic [data_w-1:0] exp_addr1;
    logic [data_w-1:0] exp_addr2;
    logic [data_w-1:0] exp_end1;
    logic [data_w-1:0] exp_end2;
    logic              exp_fault1;
    logic              exp_fault2;
    logic [tag_w-1:0]  exp_tag;
    logic [1:0]        exp_opsize;
    logic [gpr_aw-1:0] exp_dest_reg;
    logic [seg_aw-1:0] exp_dest_seg;

    rrag rrag_i (.*);

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Zero-extended read at the given operand size
    function automatic logic [31:0] model_read(input logic [2:0] idx, input logic [1:0] size);
        logic [31:0] r;
        r = model_regs[idx];
        case (size)
            size_byte: return {24'h0, r[7:0]};
            size_word: return {16'h0, r[15:0]};
            default:   return r;
        endcase
    endfunction

    function automatic logic [31:0] access_len(input logic [1:0] size);
        case (size)
            size_byte: return 32'd1;
            size_word: return 32'd2;
            default:   return 32'd4;
        endcase
    endfunction

    function automatic logic model_stall();
        logic busy;
        busy = model_pend_reg[reg_addr1] | model_pend_reg[reg_addr2] |
               model_pend_reg[reg_addr3] | model_pend_reg[reg_addr4] |
               model_pend_seg[seg_addr1] | model_pend_seg[seg_addr2];
        return (valid_in && busy) || fwd_stall;
    endfunction

    task automatic apply_reg_write(input logic [2:0] idx, input logic [31:0] data,
                                   input logic [1:0] size, input logic [tag_w-1:0] tag);
        case (size)
            size_byte: model_regs[idx][7:0] = data[7:0];
            size_word: model_regs[idx][15:0] = data[15:0];
            default:   model_regs[idx] = data;
        endcase
        if (tag == model_tag_reg[idx]) begin
            model_pend_reg[idx] = 1'b0;
        end
    endtask

    task automatic drive_reg_wb(input logic [2:0] idx, input logic [31:0] data,
                                input logic [1:0] size, input logic [tag_w-1:0] tag);
        wb_reg_en = 1'b1;
        wb_addr = idx;
        wb_data = data;
        wb_opsize = size;
        wb_tag = tag;
    endtask

    task automatic write_reg(input logic [2:0] idx, input logic [31:0] data,
                             input logic [1:0] size, input logic [tag_w-1:0] tag);
        drive_reg_wb(idx, data, size, tag);
        @(negedge clk);
        wb_reg_en = 1'b0;
        apply_reg_write(idx, data, size, tag);
    endtask

    task automatic write_seg(input logic [2:0] idx, input logic [15:0] data,
                             input logic [tag_w-1:0] tag);
        wb_seg_en = 1'b1;
        wb_seg_addr = idx;
        wb_seg_data = data;
        wb_seg_tag = tag;
        @(negedge clk);
        wb_seg_en = 1'b0;
        if (idx < 3'd6) begin
            model_seg[idx] = data;
            if (tag == model_tag_seg[idx]) begin
                model_pend_seg[idx] = 1'b0;
            end
        end
    endtask

    task automatic load_inst(input logic [2:0] r1, input logic [2:0] r2, input logic [2:0] r3,
                             input logic [2:0] r4, input logic [2:0] s1, input logic [2:0] s2,
                             input logic [1:0] size, input logic [31:0] d,
                             input logic [1:0] scale, input logic sib);
        reg_addr1 = r1;
        reg_addr2 = r2;
        reg_addr3 = r3;
        reg_addr4 = r4;
        seg_addr1 = s1;
        seg_addr2 = s2;
        opsize_in = size;
        disp = d;
        ss = scale;
        is_sib = sib;
    endtask

    task automatic load_random_inst();
        load_inst(3'(next_rand()), 3'(next_rand()), 3'(next_rand()), 3'(next_rand()),
                  3'(next_rand()), 3'(next_rand()), 2'(next_rand()), next_rand(),
                  2'(next_rand()), 1'(next_rand()));
    endtask

    task automatic capture_expected();
        logic [31:0] off1;
        logic [31:0] off2;
        logic [31:0] len;
        logic [19:0] lim1;
        logic [19:0] lim2;
        exp_reg1 = model_read(reg_addr1, opsize_in);
        exp_reg2 = model_read(reg_addr2, opsize_in);
        exp_reg3 = model_read(reg_addr3, opsize_in);
        exp_reg4 = model_read(reg_addr4, opsize_in);
        exp_seg1 = model_seg[seg_addr1];
        exp_seg2 = model_seg[seg_addr2];
        lim1 = (seg_addr1 < 3'd6) ? seg_limit_init[seg_addr1] : 20'h0;
        lim2 = (seg_addr2 < 3'd6) ? seg_limit_init[seg_addr2] : 20'h0;
        len = access_len(opsize_in);
        off1 = exp_reg2 + (is_sib ? exp_reg3 * (32'd1 << ss) : 32'd0) + disp;
        off2 = exp_reg4;
        exp_addr1 = off1 + {exp_seg1, 16'h0};
        exp_addr2 = off2 + {exp_seg2, 16'h0};
        exp_end1 = off1 + len - 32'd1 + {exp_seg1, 16'h0};
        exp_end2 = off2 + len - 32'd1 + {exp_seg2, 16'h0};
        exp_fault1 = (off1 + len - 32'd1) > 32'(lim1);
        exp_fault2 = (off2 + len - 32'd1) > 32'(lim2);
        exp_tag = model_tag;
        exp_opsize = opsize_in;
        exp_dest_reg = dest_reg_addr;
        exp_dest_seg = dest_seg_addr;
    endtask

    task automatic check_outputs(input string what);
        check_equal(32'(valid_out), 32'd1, {what, ": valid_out"});
        check_equal(32'(inst_tag), 32'(exp_tag), {what, ": inst_tag"});
        check_equal(reg1, exp_reg1, {what, ": reg1"});
        check_equal(reg2, exp_reg2, {what, ": reg2"});
        check_equal(reg3, exp_reg3, {what, ": reg3"});
        check_equal(reg4, exp_reg4, {what, ": reg4"});
        check_equal(32'(seg1), 32'(exp_seg1), {what, ": seg1"});
        check_equal(32'(seg2), 32'(exp_seg2), {what, ": seg2"});
        check_equal(mem_addr1, exp_addr1, {what, ": mem_addr1"});
        check_equal(mem_addr2, exp_addr2, {what, ": mem_addr2"});
        check_equal(mem_addr1_end, exp_end1, {what, ": mem_addr1_end"});
        check_equal(mem_addr2_end, exp_end2, {what, ": mem_addr2_end"});
        check_equal(32'(seg_fault1), 32'(exp_fault1), {what, ": seg_fault1"});
        check_equal(32'(seg_fault2), 32'(exp_fault2), {what, ": seg_fault2"});
        check_equal(32'(opsize_out), 32'(exp_opsize), {what, ": opsize_out"});
        check_equal(32'(dest_reg_out), 32'(exp_dest_reg), {what, ": dest_reg_out"});
        check_equal(32'(dest_seg_out), 32'(exp_dest_seg), {what, ": dest_seg_out"});
    endtask

    // One-cycle acceptance, result visible on the next falling edge
    task automatic issue(input string what);
        valid_in = 1'b1;
        #2;
        check_equal(32'(stall), 32'(model_stall()), {what, ": stall"});
        capture_expected();
        if (dest_reg_en) begin
            model_pend_reg[dest_reg_addr] = 1'b1;
            model_tag_reg[dest_reg_addr] = model_tag;
        end
        if (dest_seg_en && dest_seg_addr < 3'd6) begin
            model_pend_seg[dest_seg_addr] = 1'b1;
            model_tag_seg[dest_seg_addr] = model_tag;
        end
        model_tag = model_tag + 7'd1;
        @(negedge clk);
        valid_in = 1'b0;
        dest_reg_en = 1'b0;
        dest_seg_en = 1'b0;
        check_outputs(what);
    endtask

    task automatic init_inputs();
        reset = 1'b1;
        valid_in = 1'b0;
        load_inst(3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, size_dword, 32'd0, 2'd0, 1'b0);
        dest_reg_en = 1'b0;
        dest_reg_addr = '0;
        dest_seg_en = 1'b0;
        dest_seg_addr = '0;
        drive_reg_wb(3'd0, 32'd0, size_dword, 7'd0);
        wb_reg_en = 1'b0;
        wb_seg_en = 1'b0;
        wb_seg_addr = '0;
        wb_seg_data = '0;
        wb_seg_tag = '0;
        fwd_stall = 1'b0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
            model_tag_reg[i] = '0;
            model_seg[i] = '0;
            model_tag_seg[i] = '0;
        end
        model_pend_reg = '0;
        model_pend_seg = '0;
        model_tag = '0;
    endtask

    `include "rrag_tests.svh"

    initial begin
        init_inputs();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_equal(32'(valid_out), 32'd0, "valid_out after reset");
        check_equal(32'(stall), 32'd0, "stall after reset");
        test_partial_writes();
        test_addr_gen();
        test_limit_faults();
        test_scoreboard();
        test_tags_backpressure();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
verilog/rrag_pkg.sv
verilog/gpr_file.sv
verilog/seg_file.sv
verilog/addr_gen.sv
verilog/rrag.sv
sim/rrag_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rrag_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exit status is ignored here, the log decides pass or fail
run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
